// ==== Makefile ====
# Verilator build and run for the frame transmitter

VERILATOR ?= verilator
TOP       ?= tb_frame_tx
RTL_TOP   ?= frame_tx
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
RTL_SRCS  ?= frame_pkg.sv count_decr.sv frame_ctrl.sv byte_gen.sv frame_checksum.sv frame_tx.sv
FAIL_MSG  := Verification failed
PASS_MSG  := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timescale 1ns/1ps --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== byte_gen.sv ====
// Pattern generator that presents the next frame bytes and advances by the bytes sent

`timescale 1ns/1ps

module byte_gen (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        load,
  input  logic [frame_pkg::BYTE_W-1:0]                seed,
  input  logic [frame_pkg::CNT_W-1:0]                 step,
  output logic [frame_pkg::LANES*frame_pkg::BYTE_W-1:0] data
);

  import frame_pkg::*;

  // Value of the next byte still to be sent
  logic [BYTE_W-1:0] next_q;

  // Seed on load, then move forward by however many bytes left this beat.
  // The byte arithmetic wraps modulo 256 on its own
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      next_q <= '0;
    end else if (load) begin
      next_q <= seed;
    end else if (step != '0) begin
      next_q <= next_q + BYTE_W'(step);
    end
  end

  // ------------------------------
  // Lane fill
  // ------------------------------

  // Lane i carries the next byte plus i, earliest byte in the low lane.
  // Lanes above the beat's count show bytes not yet sent and are ignored
  for (genvar i = 0; i < LANES; i++) begin : gen_lane
    assign data[i*BYTE_W +: BYTE_W] = next_q + BYTE_W'(i);
  end

endmodule : byte_gen

// ==== count_decr.sv ====
// Remaining-length counter that loads, decrements by a variable step and exposes its next value

`timescale 1ns/1ps

module count_decr (
  input  logic                         clk,
  input  logic                         arst_n,
  // Load strobe, init_len is sampled in the same cycle
  input  logic                         load,
  input  logic [frame_pkg::LEN_W-1:0]  init_len,
  // Bytes consumed this cycle, zero means no decrement
  input  logic [frame_pkg::CNT_W-1:0]  step,
  output logic [frame_pkg::LEN_W-1:0]  remain,
  output logic [frame_pkg::LEN_W-1:0]  remain_next
);

  import frame_pkg::*;

  // ------------------------------
  // Next value
  // ------------------------------

  logic [LEN_W-1:0] base_value;
  logic [LEN_W-1:0] step_ext;
  logic             update;

  // The step is widened to the counter width before the subtraction
  assign step_ext = LEN_W'(step);

  // A load that coincides with a step applies the step to the loaded value,
  // so the first beat of a frame could be taken in the loading cycle
  assign base_value = load ? init_len : remain;

  // The controller never asks for more than remains, so no wrap handling
  assign remain_next = base_value - step_ext;

  // The register only moves on a load or a non-zero step
  assign update = load || (step != '0);

  // ------------------------------
  // Counter register
  // ------------------------------

  // Counter comes out of reset at zero, matching an idle transmitter
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      remain <= '0;
    end else if (update) begin
      remain <= remain_next;
    end
  end

  // When neither load nor step is present remain_next equals remain,
  // which lets the controller chain on it without checking the strobes

endmodule : count_decr

// ==== frame_checksum.sv ====
// Running modulo-256 sum of the bytes sent in a frame

`timescale 1ns/1ps

module frame_checksum (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        load,
  input  logic [frame_pkg::CNT_W-1:0]                 step,
  input  logic [frame_pkg::LANES*frame_pkg::BYTE_W-1:0] data,
  output logic [frame_pkg::BYTE_W-1:0]                csum
);

  import frame_pkg::*;

  logic [BYTE_W-1:0] sum_next;

  // Only the lanes below the step count are part of the frame
  always_comb begin
    sum_next = csum;
    for (int i = 0; i < LANES; i++) begin
      if (CNT_W'(i) < step) begin
        sum_next = sum_next + data[i*BYTE_W +: BYTE_W];
      end
    end
  end

  // A new frame starts from zero, and the total holds until the next load
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      csum <= '0;
    end else if (load) begin
      csum <= '0;
    end else if (step != '0) begin
      csum <= sum_next;
    end
  end

endmodule : frame_checksum

// ==== frame_ctrl.sv ====
// Frame sequencer FSM that steps through payload, checksum and done and sizes each beat

`timescale 1ns/1ps

module frame_ctrl (
  input  logic                         clk,
  input  logic                         arst_n,
  // Command from the host
  input  logic                         start,
  input  logic [frame_pkg::LEN_W-1:0]  len,
  // Level that freezes the transmitter
  input  logic                         stall,
  // Counter feedback
  input  logic [frame_pkg::LEN_W-1:0]  remain,
  input  logic [frame_pkg::LEN_W-1:0]  remain_next,
  // Strobes to the counter, generator and checksum
  output logic                         load,
  output logic [frame_pkg::CNT_W-1:0]  step,
  // Status towards the outside
  output logic                         out_valid,
  output logic                         csum_valid,
  output logic                         busy,
  output logic                         done
);

  import frame_pkg::*;

  // ------------------------------
  // State
  // ------------------------------

  enum logic [1:0] {
    ST_IDLE,
    ST_PAYLOAD,
    ST_CSUM,
    ST_DONE
  } state_q, state_d;

  logic accept;
  logic beat;
  logic [CNT_W-1:0] beat_bytes;

  // A command is taken only when no frame is in flight and the length is non-zero.
  // The done cycle already counts as free, so back-to-back frames lose no cycle
  assign accept = start && (len != '0) && ((state_q == ST_IDLE) || (state_q == ST_DONE));

  // One payload beat per unstalled cycle in the payload state
  assign beat = (state_q == ST_PAYLOAD) && !stall;

  // Up to LANES bytes per beat, fewer on the tail of the frame
  assign beat_bytes = (remain >= LEN_W'(LANES)) ? CNT_W'(LANES) : CNT_W'(remain);

  // ------------------------------
  // Outputs
  // ------------------------------

  assign load       = accept;
  assign step       = beat ? beat_bytes : '0;
  assign out_valid  = beat;
  assign csum_valid = (state_q == ST_CSUM) && !stall;

  // Busy spans payload and checksum and drops with the done pulse
  assign busy = (state_q == ST_PAYLOAD) || (state_q == ST_CSUM);
  assign done = (state_q == ST_DONE);

  // ------------------------------
  // Transitions
  // ------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) state_d = ST_PAYLOAD;
      end
      ST_PAYLOAD: begin
        // Leave on the beat that empties the counter, seen through remain_next
        if (beat && (remain_next == '0)) state_d = ST_CSUM;
      end
      ST_CSUM: begin
        // The checksum beat waits out any stall
        if (!stall) state_d = ST_DONE;
      end
      ST_DONE: begin
        state_d = accept ? ST_PAYLOAD : ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule : frame_ctrl

// ==== frame_pkg.sv ====
// Frame transmitter package with the widths and limits shared across the design

package frame_pkg;

  // ------------------------------
  // Lengths
  // ------------------------------

  // Width of the frame length and of the remaining-length counter
  localparam int LEN_W = 8;

  // Largest frame length in bytes that the transmitter accepts
  localparam int MAX_FRAME_LEN = 255;

  // ------------------------------
  // Output lanes
  // ------------------------------

  // Number of byte lanes on the output, so at most this many bytes per beat
  localparam int LANES = 2;

  // Width of the per-beat byte count, which holds 0 up to LANES
  localparam int CNT_W = 2;

  // Width of one byte on a lane
  localparam int BYTE_W = 8;

endpackage : frame_pkg

// ==== frame_tx.sv ====
// Frame transmitter top that joins the controller, length counter, byte generator and checksum

`timescale 1ns/1ps

module frame_tx (
  input  logic                                          clk,
  input  logic                                          arst_n,
  // Host command, len and seed sampled with the start pulse
  input  logic                                          start,
  input  logic [frame_pkg::LEN_W-1:0]                   len,
  input  logic [frame_pkg::BYTE_W-1:0]                  seed,
  input  logic                                          stall,
  // Payload beats, earlier byte in the low lane
  output logic                                          out_valid,
  output logic [frame_pkg::CNT_W-1:0]                   out_count,
  output logic [frame_pkg::LANES*frame_pkg::BYTE_W-1:0] out_data,
  // Checksum beat
  output logic                                          csum_valid,
  output logic [frame_pkg::BYTE_W-1:0]                  csum,
  // Frame status
  output logic                                          busy,
  output logic                                          done
);

  import frame_pkg::*;

  // ------------------------------
  // Internal wiring
  // ------------------------------

  logic             load;
  logic [CNT_W-1:0] step;
  logic [LEN_W-1:0] remain;
  logic [LEN_W-1:0] remain_next;

  // The beat size is the controller's step, zero outside valid beats
  assign out_count = step;

  // A zero length is dropped by the controller, which then stays idle
  frame_ctrl u_ctrl (
    .clk         (clk),
    .arst_n      (arst_n),
    .start       (start),
    .len         (len),
    .stall       (stall),
    .remain      (remain),
    .remain_next (remain_next),
    .load        (load),
    .step        (step),
    .out_valid   (out_valid),
    .csum_valid  (csum_valid),
    .busy        (busy),
    .done        (done)
  );

  count_decr u_count (
    .clk         (clk),
    .arst_n      (arst_n),
    .load        (load),
    .init_len    (len),
    .step        (step),
    .remain      (remain),
    .remain_next (remain_next)
  );

  byte_gen u_gen (
    .clk    (clk),
    .arst_n (arst_n),
    .load   (load),
    .seed   (seed),
    .step   (step),
    .data   (out_data)
  );

  // The checksum sees the same lanes and step that leave on the output
  frame_checksum u_csum (
    .clk    (clk),
    .arst_n (arst_n),
    .load   (load),
    .step   (step),
    .data   (out_data),
    .csum   (csum)
  );

endmodule : frame_tx

// ==== sim.f ====
frame_pkg.sv
count_decr.sv
frame_ctrl.sv
byte_gen.sv
frame_checksum.sv
frame_tx.sv
tb_frame_tx.sv

// ==== tb_frame_tx.sv ====
// Self-checking testbench for the frame transmitter with a reference model and LCG stimulus

`timescale 1ns/1ps

module tb_frame_tx;

  import frame_pkg::*;

  // ------------------------------
  // DUT signals
  // ------------------------------

  logic                    clk;
  logic                    arst_n;
  logic                    start;
  logic [LEN_W-1:0]        len;
  logic [BYTE_W-1:0]       seed;
  logic                    stall;
  logic                    out_valid;
  logic [CNT_W-1:0]        out_count;
  logic [LANES*BYTE_W-1:0] out_data;
  logic                    csum_valid;
  logic [BYTE_W-1:0]       csum;
  logic                    busy;
  logic                    done;

  frame_tx u_dut (.*);

  // Bookkeeping for the run
  logic [31:0] rng_state;
  int          errors;
  int          tests_passed;
  int          tests_failed;
  int          cycle_cnt;
  int          cycle_limit;
  int          frame_len [10];

  // Reference model state, updated at every rising edge
  logic              exp_busy;
  logic              exp_done;
  int                exp_remain;
  logic [BYTE_W-1:0] exp_next;
  logic [BYTE_W-1:0] exp_sum;

  // What the DUT actually sent in the current frame
  int dut_bytes;
  int dut_csum_beats;
  int last_count;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // ------------------------------
  // Helpers
  // ------------------------------

  // Plain LCG, upper bits are the usable ones
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  function automatic int rand_pct();
    return int'((next_rand() >> 16) % 32'd100);
  endfunction

  // Bytes in one beat are capped by the lane count and by what is left
  function automatic int beat_size(input int remaining);
    return (remaining >= LANES) ? LANES : remaining;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("** Error: %s expected 0x%0h, got 0x%0h at %0t", name, expected, actual, $time);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  // ------------------------------
  // Reference model and checks
  // ------------------------------

  // Outputs are read in the active region of the rising edge, before the DUT
  // registers take their new values, so this is the value the edge samples
  always @(posedge clk) begin
    logic              want_valid;
    logic              want_csum;
    logic              accept;
    int                n;
    logic [BYTE_W-1:0] lane_exp;
    if (!arst_n) begin
      exp_busy   = 1'b0;
      exp_done   = 1'b0;
      exp_remain = 0;
      exp_next   = '0;
      exp_sum    = '0;
    end else begin
      want_valid = exp_busy && (exp_remain != 0) && !stall;
      want_csum  = exp_busy && (exp_remain == 0) && !stall;
      // Start counts only when idle and with a non-zero length
      accept     = start && (len != '0) && !exp_busy;
      n          = beat_size(exp_remain);
      check_value("busy", 32'(exp_busy), 32'(busy));
      check_value("done", 32'(exp_done), 32'(done));
      check_value("out_valid", 32'(want_valid), 32'(out_valid));
      check_value("csum_valid", 32'(want_csum), 32'(csum_valid));
      if (want_valid) begin
        check_value("out_count", n, 32'(out_count));
        for (int i = 0; i < n; i++) begin
          // Byte k of the frame is the seed plus k, wrapping at 256
          lane_exp = exp_next + BYTE_W'(i);
          check_value($sformatf("out_data lane %0d", i), 32'(lane_exp),
                      32'(out_data[i*BYTE_W +: BYTE_W]));
          exp_sum = exp_sum + lane_exp;
        end
        exp_next   = exp_next + BYTE_W'(n);
        exp_remain = exp_remain - n;
      end
      if (want_csum) begin
        check_value("csum", 32'(exp_sum), 32'(csum));
        exp_busy = 1'b0;
      end
      if (out_valid) begin
        dut_bytes  += int'(out_count);
        last_count  = int'(out_count);
      end
      if (csum_valid) begin
        dut_csum_beats++;
      end
      // Done follows the checksum beat by one cycle
      exp_done = want_csum;
      if (accept) begin
        exp_busy       = 1'b1;
        exp_remain     = int'(len);
        exp_next       = seed;
        exp_sum        = '0;
        dut_bytes      = 0;
        dut_csum_beats = 0;
        last_count     = 0;
      end
    end
  end

  // Protocol rules that hold at every edge
  done_after_csum: assert property (@(posedge clk) disable iff (!arst_n) csum_valid |=> done)
    else begin
      $display("Protocol failure: no done pulse right after the checksum beat at %0t", $time);
      errors++;
    end

  one_beat_kind: assert property (@(posedge clk) disable iff (!arst_n)
                                  !(out_valid && csum_valid))
    else begin
      $display("Protocol failure: payload and checksum beat in the same cycle at %0t", $time);
      errors++;
    end

  done_not_busy: assert property (@(posedge clk) disable iff (!arst_n) done |-> !busy)
    else begin
      $display("Protocol failure: busy still high during done at %0t", $time);
      errors++;
    end

  // Watchdog over the whole run
  always @(posedge clk) begin
    cycle_cnt++;
    if ((cycle_limit != 0) && (cycle_cnt > cycle_limit)) begin
      $display("Timeout: the run went past its limit of %0d cycles", cycle_limit);
      $display("Verification failed");
      $finish;
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------

  // Sends one frame and waits for done; a second start can be injected mid-frame
  task automatic run_frame(input string name, input int flen, input logic [BYTE_W-1:0] fseed,
                           input int stall_pct, input bit inject);
    int cycles;
    int limit;
    int err_before;
    bit got_done;
    err_before = errors;
    limit      = 2 * flen + 20;
    cycles     = 0;
    got_done   = 1'b0;
    @(negedge clk);
    start = 1'b1;
    len   = LEN_W'(flen);
    seed  = fseed;
    stall = 1'b0;
    while (!got_done && (cycles < limit)) begin
      @(negedge clk);
      start = 1'b0;
      stall = (stall_pct != 0) && (rand_pct() < stall_pct);
      if (inject && (cycles == 3)) begin
        start = 1'b1;
        len   = LEN_W'(7);
        seed  = ~fseed;
      end
      @(posedge clk);
      cycles++;
      if (done) begin
        got_done = 1'b1;
      end
    end
    // The model has taken the edge that carried done by the next falling edge
    @(negedge clk);
    if (!got_done) begin
      $display("Failure: frame %s saw no done pulse within %0d cycles", name, limit);
      errors++;
    end
    check_value("bytes sent", flen, dut_bytes);
    check_value("checksum beats", 1, dut_csum_beats);
    // An odd length ends with a single byte in the low lane
    check_value("last out_count", ((flen % 2) == 1) ? 1 : 2, last_count);
    if (stall_pct == 0) begin
      check_value("cycles start to done", (flen + 1) / 2 + 2, cycles);
    end
    report_test(name, err_before);
  endtask

  task automatic zero_len_start();
    int err_before;
    err_before = errors;
    @(negedge clk);
    start = 1'b1;
    len   = '0;
    seed  = 8'h5a;
    @(negedge clk);
    start = 1'b0;
    repeat (4) begin
      @(posedge clk);
      check_value("busy", 0, 32'(busy));
    end
    report_test("zero_len_start", err_before);
  endtask

  initial begin
    int total;
    int err_before;
    rng_state = 32'd19;
    arst_n    = 1'b0;
    start     = 1'b0;
    len       = '0;
    seed      = '0;
    stall     = 1'b0;
    // Lengths are drawn first so the cycle limit can cover every frame
    for (int i = 0; i < 10; i++) begin
      frame_len[i] = 1 + int'((next_rand() >> 16) % 32'(MAX_FRAME_LEN));
    end
    total = 20 + 20 + (2 * 40 + 20) + (2 * 1 + 20) + (2 * MAX_FRAME_LEN + 20);
    foreach (frame_len[i]) begin
      total += 2 * frame_len[i] + 20;
    end
    cycle_limit = total;

    // Reset for two cycles, then idle with start low
    err_before = errors;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    repeat (5) begin
      @(posedge clk);
      check_value("busy", 0, 32'(busy));
      check_value("out_valid", 0, 32'(out_valid));
      check_value("csum_valid", 0, 32'(csum_valid));
      check_value("done", 0, 32'(done));
    end
    report_test("reset_idle", err_before);

    // Random frames, the first six without stall and the rest with it
    for (int i = 0; i < 10; i++) begin
      run_frame($sformatf("frame_%0d_len_%0d", i, frame_len[i]), frame_len[i],
                BYTE_W'(next_rand() >> 16), (i < 6) ? 0 : 35, 1'b0);
    end

    run_frame("start_while_busy", 40, BYTE_W'(next_rand() >> 16), 0, 1'b1);
    zero_len_start();
    run_frame("len_one", 1, 8'hff, 0, 1'b0);
    run_frame("len_max", MAX_FRAME_LEN, 8'h80, 0, 1'b0);

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if ((errors == 0) && (tests_failed == 0)) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule : tb_frame_tx
